// File: run_sim.sh
#!/usr/bin/env bash
# compiles and runs the sifh testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal --top-module tb_sifh \
    -Mdir "$OBJ" -o tb_sifh -f sifh.f
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

"./$OBJ/tb_sifh" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^>>> PASS$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: sifh.f
+incdir+verilog
verilog/sifh_pkg.sv
verilog/hist_bus_if.sv
verilog/bin_stream_if.sv
verilog/hist_bram.sv
verilog/his_builder_fsm.sv
verilog/peak_finder.sv
verilog/sifh_top.sv
tests/tb_sifh.sv

// File: tests/tb_sifh.sv
`timescale 1ns/100ps
`include "sifh_consts.svh"

module tb_sifh import sifh_pkg::*; ();

    localparam int FRAMES    = 2;
    localparam int ROWS      = FRAMES * `ACQ_NUM * `PIXEL_NUM * `DATA_NUM;
    localparam int FRAME_ROW = ROWS / FRAMES;
    localparam int BINS      = 1 << `NB;
    localparam int SAT       = (1 << `PEAK_MAX) - 1;
    // per frame 64 clear, up to 96 input, 2 drain, 70 readout cycles, wide margin.
    localparam int TIMEOUT_CYCLES = 2500;

    logic       clk;
    logic       res;
    logic       wr_en;
    bin_addr_t  addr;
    logic       accepting;
    logic       bin_valid;
    bin_count_t bin_counts;
    pixel_idx_t his_num;
    logic       peak_valid;
    bin_addr_t  peak_bin;
    bin_count_t peak_count;
    logic       data_finish;

    // one photon per row, hex digits frame, acquisition, pixel, bin.
    logic [15:0] stim [ROWS] = '{
        16'h0003, 16'h0003, 16'h0003, 16'h0003, 16'h0015, 16'h0015, 16'h0019, 16'h0019,
        16'h002D, 16'h002D, 16'h0026, 16'h0021, 16'h003F, 16'h003F, 16'h003F, 16'h003E,
        16'h0103, 16'h0103, 16'h0103, 16'h0103, 16'h0119, 16'h011C, 16'h0110, 16'h0115,
        16'h0126, 16'h0120, 16'h012F, 16'h0128, 16'h0131, 16'h0132, 16'h013F, 16'h0133,
        16'h1000, 16'h1001, 16'h1002, 16'h1003, 16'h1013, 16'h1013, 16'h1013, 16'h1013,
        16'h102E, 16'h102E, 16'h102E, 16'h102E, 16'h1037, 16'h1036, 16'h1035, 16'h1034,
        16'h1104, 16'h1104, 16'h1104, 16'h1101, 16'h1113, 16'h1113, 16'h111A, 16'h111B,
        16'h112E, 16'h112E, 16'h112E, 16'h112E, 16'h1136, 16'h1135, 16'h1136, 16'h1139
    };

    int exp_hist [FRAMES][`PIXEL_NUM][BINS];
    int got_count[$];
    int got_pixel[$];
    int got_peak_bin[$];
    int got_peak_count[$];
    int finish_count;
    int peaks_at_finish;
    int cycles;
    int errors;
    int test_errors;
    int tests_run;
    int tests_failed;

    sifh_top i_dut (
        .clk         (clk),
        .res         (res),
        .wr_en       (wr_en),
        .addr        (addr),
        .accepting   (accepting),
        .bin_valid   (bin_valid),
        .bin_counts  (bin_counts),
        .his_num     (his_num),
        .peak_valid  (peak_valid),
        .peak_bin    (peak_bin),
        .peak_count  (peak_count),
        .data_finish (data_finish)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the DUT never finished the run", cycles);
        $display(">>> FAIL");
        $finish;
    end

    // outputs settle after the rising edge.
    always @(negedge clk) begin
        if (res) begin
            if (bin_valid) begin
                got_count.push_back(int'(bin_counts));
                got_pixel.push_back(int'(his_num));
            end
            if (peak_valid) begin
                got_peak_bin.push_back(int'(peak_bin));
                got_peak_count.push_back(int'(peak_count));
            end
            if (data_finish) begin
                finish_count++;
                peaks_at_finish = got_peak_bin.size();
            end
        end
    end

    task automatic check_eq(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("FAIL %s expected %0d actual %0d", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, test_errors);
            tests_failed++;
        end
        errors += test_errors;
        test_errors = 0;
    endtask

    // hits per pixel and bin, saturated.
    function automatic void build_model();
        int f;
        int a;
        int p;
        int b;
        for (int r = 0; r < ROWS; r++) begin
            f = int'(stim[r][15:12]);
            a = int'(stim[r][11:8]);
            p = int'(stim[r][7:4]);
            b = int'(stim[r][3:0]);
            if (f != r / FRAME_ROW || p != (r / `DATA_NUM) % `PIXEL_NUM ||
                a != (r / (`DATA_NUM * `PIXEL_NUM)) % `ACQ_NUM) begin
                $display("stimulus table row %0d is out of order", r);
                errors++;
            end else if (exp_hist[f][p][b] < SAT) begin
                exp_hist[f][p][b]++;
            end
        end
    endfunction

    // lowest bin among those holding the maximum.
    task automatic expected_peak(input int f, input int p, output int bin, output int count);
        bin = 0;
        count = exp_hist[f][p][0];
        for (int b = 1; b < BINS; b++) begin
            if (exp_hist[f][p][b] > count) begin
                bin = b;
                count = exp_hist[f][p][b];
            end
        end
    endtask

    task automatic clear_phase(input string name);
        int n;
        n = 0;
        while (!accepting && n < 2 * `RAM_SIZE) begin
            wr_en = 1'b1;   // ignored while clearing.
            addr  = bin_addr_t'($urandom);
            @(posedge clk);
            #1;
            n++;
        end
        wr_en = 1'b0;
        check_eq({name, " cycles to accepting"}, `RAM_SIZE, n);
        end_test(name);
    endtask

    task automatic input_phase(input int f);
        int    gap;
        int    prev;
        string name;
        name = $sformatf("input_f%0d", f);
        prev = -1;
        got_count.delete();
        got_pixel.delete();
        got_peak_bin.delete();
        got_peak_count.delete();
        for (int r = f * FRAME_ROW; r < (f + 1) * FRAME_ROW; r++) begin
            // repeats go back to back to hit the ram bypass.
            gap = (int'(stim[r][3:0]) == prev) ? 0 : int'($urandom % 3);
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            if (!accepting) begin
                $display("%s: accepting was low before photon %0d", name, r);
                test_errors++;
            end
            wr_en = 1'b1;
            addr  = stim[r][3:0];
            @(posedge clk);
            #1;
            wr_en = 1'b0;
            prev  = int'(stim[r][3:0]);
        end
        if (accepting) begin
            $display("%s: accepting stayed high after the last photon", name);
            test_errors++;
        end
        end_test(name);
    endtask

    task automatic readout_phase(input int f);
        int    p;
        int    b;
        int    pk_bin;
        int    pk_count;
        string name;
        while (!data_finish) begin
            wr_en = 1'b1;   // drain, readout and finish ignore photons.
            addr  = bin_addr_t'($urandom);
            @(posedge clk);
            #1;
        end
        wr_en = 1'b0;
        name = $sformatf("counts_f%0d", f);
        check_eq({name, " bins"}, `RAM_SIZE, got_count.size());
        for (int i = 0; i < got_count.size() && i < `RAM_SIZE; i++) begin
            p = i / BINS;
            b = i % BINS;
            check_eq($sformatf("%s pixel %0d bin %0d count", name, p, b),
                exp_hist[f][p][b], got_count[i]);
            check_eq($sformatf("%s bin %0d his_num", name, i), p, got_pixel[i]);
        end
        end_test(name);
        name = $sformatf("peaks_f%0d", f);
        check_eq({name, " results"}, `PIXEL_NUM, got_peak_bin.size());
        for (int q = 0; q < got_peak_bin.size() && q < `PIXEL_NUM; q++) begin
            expected_peak(f, q, pk_bin, pk_count);
            check_eq($sformatf("%s pixel %0d peak_bin", name, q), pk_bin, got_peak_bin[q]);
            check_eq($sformatf("%s pixel %0d peak_count", name, q), pk_count,
                got_peak_count[q]);
        end
        end_test(name);
    endtask

    initial begin
        void'($urandom(32'hc356));
        res          = 1'b0;
        wr_en        = 1'b0;
        addr         = '0;
        finish_count = 0;
        errors       = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        build_model();
        repeat (4) @(posedge clk);
        #1;
        res = 1'b1;
        clear_phase("clear_f0");
        for (int f = 0; f < FRAMES; f++) begin
            input_phase(f);
            readout_phase(f);
            clear_phase($sformatf("clear_after_f%0d", f));
            check_eq($sformatf("frame_end_f%0d finish pulses", f), f + 1, finish_count);
            check_eq($sformatf("frame_end_f%0d peaks before finish", f), `PIXEL_NUM,
                peaks_at_finish);
            end_test($sformatf("frame_end_f%0d", f));
        end
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: verilog/bin_stream_if.sv
`timescale 1ns/100ps

interface bin_stream_if import sifh_pkg::*; ();

    logic       valid;
    bin_count_t count;
    logic       last;    // bin 15 of the pixel.
    pixel_idx_t pixel;

    modport source (
        output valid, count, last, pixel
    );

    modport sink (
        input valid, count, last, pixel
    );

endinterface

// File: verilog/his_builder_fsm.sv
`timescale 1ns/100ps
`include "sifh_consts.svh"

module his_builder_fsm import sifh_pkg::*; (
    input  logic         clk,
    input  logic         res,
    input  logic         wr_en,
    input  bin_addr_t    addr,
    output logic         accepting,
    output pixel_idx_t   his_num,
    output logic         data_finish,
    hist_bus_if.builder  bus,
    bin_stream_if.source stream
);

    localparam int IN_W  = ($clog2(`DATA_NUM) > 0) ? $clog2(`DATA_NUM) : 1;
    localparam int ACQ_W = ($clog2(`ACQ_NUM) > 0) ? $clog2(`ACQ_NUM) : 1;

    hist_state_t      state;
    ram_addr_t        sweep_addr;   // clear and read address, short timer elsewhere.
    logic [IN_W-1:0]  input_count;
    pixel_idx_t       pixel_count;
    logic [ACQ_W-1:0] acq_count;
    logic             photon;
    logic             sweep_end;
    logic             stream_valid;
    logic             stream_last;

    assign accepting = (state == INPUT);
    assign photon    = accepting && wr_en;
    assign sweep_end = (sweep_addr == ram_addr_t'(`RAM_SIZE - 1));

    assign bus.inc_en   = photon;
    assign bus.inc_addr = {pixel_count, addr};
    assign bus.clr_en   = (state == CLEAR);
    assign bus.clr_addr = sweep_addr;
    assign bus.rd_en    = (state == READOUT);
    assign bus.rd_addr  = sweep_addr;

    assign stream.valid = stream_valid;
    assign stream.count = bus.rd_data;
    assign stream.last  = stream_last;
    assign stream.pixel = his_num;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state       <= CLEAR;
            sweep_addr  <= '0;
            input_count <= '0;
            pixel_count <= '0;
            acq_count   <= '0;
            data_finish <= 1'b0;
        end else begin
            data_finish <= 1'b0;
            case (state)
                CLEAR: begin
                    sweep_addr <= sweep_addr + 1'b1;   // wraps to 0 on the last word.
                    if (sweep_end) begin
                        state <= INPUT;
                    end
                end
                INPUT: begin
                    if (photon) begin
                        if (input_count == IN_W'(`DATA_NUM - 1)) begin
                            input_count <= '0;
                            if (pixel_count == pixel_idx_t'(`PIXEL_NUM - 1)) begin
                                pixel_count <= '0;
                                if (acq_count == ACQ_W'(`ACQ_NUM - 1)) begin
                                    acq_count <= '0;
                                    state     <= DRAIN;
                                end else begin
                                    acq_count <= acq_count + 1'b1;
                                end
                            end else begin
                                pixel_count <= pixel_count + 1'b1;
                            end
                        end else begin
                            input_count <= input_count + 1'b1;
                        end
                    end
                end
                DRAIN: begin
                    // two cycles, lets the ram increment pipeline empty.
                    if (sweep_addr[0]) begin
                        sweep_addr <= '0;
                        state      <= READOUT;
                    end else begin
                        sweep_addr <= sweep_addr + 1'b1;
                    end
                end
                READOUT: begin
                    sweep_addr <= sweep_addr + 1'b1;
                    if (sweep_end) begin
                        state <= FINISH;
                    end
                end
                FINISH: begin
                    // waits out the last bin and its peak result.
                    if (sweep_addr[0]) begin
                        sweep_addr  <= '0;
                        data_finish <= 1'b1;
                        state       <= CLEAR;
                    end else begin
                        sweep_addr <= sweep_addr + 1'b1;
                    end
                end
                default: begin
                    sweep_addr <= '0;
                    state      <= CLEAR;
                end
            endcase
        end
    end

    // flags follow rd_data by one cycle.
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            stream_valid <= 1'b0;
            stream_last  <= 1'b0;
            his_num      <= '0;
        end else begin
            stream_valid <= bus.rd_en;
            stream_last  <= bus.rd_en && (sweep_addr[`NB-1:0] == {`NB{1'b1}});
            if (bus.rd_en) begin
                his_num <= sweep_addr[`PIX_W+`NB-1:`NB];
            end
        end
    end

    assert property (@(posedge clk) disable iff (!res)
        state inside {CLEAR, INPUT, DRAIN, READOUT, FINISH});

    assert property (@(posedge clk) disable iff (!res)
        stream.valid |-> (state == READOUT || $past(state) == READOUT));

endmodule

// File: verilog/hist_bram.sv
`timescale 1ns/100ps
`include "sifh_consts.svh"

module hist_bram import sifh_pkg::*; (
    input logic     clk,
    input logic     res,
    hist_bus_if.ram bus
);

    bin_count_t mem [`RAM_SIZE];

    logic       s1_valid;   // increment waiting for its write.
    ram_addr_t  s1_addr;
    bin_count_t s1_count;
    bin_count_t inc_next;
    logic       fwd_hit;

    // saturating increment of the word read in stage one.
    assign inc_next = (s1_count == {`PEAK_MAX{1'b1}}) ? s1_count : s1_count + 1'b1;

    // same word still in flight, so the array holds a stale count.
    assign fwd_hit = s1_valid && (s1_addr == bus.inc_addr);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= bus.inc_en;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.inc_en) begin
            s1_addr  <= bus.inc_addr;
            s1_count <= fwd_hit ? inc_next : mem[bus.inc_addr];
        end
        if (bus.clr_en) begin
            mem[bus.clr_addr] <= '0;
        end else if (s1_valid) begin
            mem[s1_addr] <= inc_next;   // stage two write.
        end
        if (bus.rd_en) begin
            bus.rd_data <= mem[bus.rd_addr];
        end
    end

    // pending writes must not meet a clear or a read.
    assert property (@(posedge clk) disable iff (!res)
        $onehot0({bus.inc_en || s1_valid, bus.clr_en, bus.rd_en}));

endmodule

// File: verilog/hist_bus_if.sv
`timescale 1ns/100ps

interface hist_bus_if import sifh_pkg::*; ();

    logic       inc_en;    // one strobe per photon.
    ram_addr_t  inc_addr;
    logic       clr_en;
    ram_addr_t  clr_addr;
    logic       rd_en;
    ram_addr_t  rd_addr;
    bin_count_t rd_data;   // valid one cycle after rd_en.

    modport builder (
        output inc_en, inc_addr,
        output clr_en, clr_addr,
        output rd_en, rd_addr,
        input  rd_data
    );

    modport ram (
        input  inc_en, inc_addr,
        input  clr_en, clr_addr,
        input  rd_en, rd_addr,
        output rd_data
    );

endinterface

// File: verilog/peak_finder.sv
`timescale 1ns/100ps

module peak_finder import sifh_pkg::*; (
    input  logic        clk,
    input  logic        res,
    bin_stream_if.sink  stream,
    output logic        peak_valid,
    output bin_addr_t   peak_bin,
    output bin_count_t  peak_count
);

    bin_addr_t  bin_idx;   // position within the pixel.
    bin_addr_t  run_bin;
    bin_count_t run_max;
    logic       take;
    bin_addr_t  cand_bin;
    bin_count_t cand_max;

    // strictly greater, a tie keeps the lower bin.
    assign take     = stream.count > run_max;
    assign cand_bin = take ? bin_idx : run_bin;
    assign cand_max = take ? stream.count : run_max;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            peak_valid <= 1'b0;
            peak_bin   <= '0;
            peak_count <= '0;
            bin_idx    <= '0;
            run_bin    <= '0;
            run_max    <= '0;
        end else begin
            peak_valid <= 1'b0;
            if (stream.valid) begin
                if (stream.last) begin
                    peak_valid <= 1'b1;
                    peak_bin   <= cand_bin;
                    peak_count <= cand_max;
                    bin_idx    <= '0;   // next pixel.
                    run_bin    <= '0;
                    run_max    <= '0;
                end else begin
                    bin_idx <= bin_idx + 1'b1;
                    run_bin <= cand_bin;
                    run_max <= cand_max;
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (!res)
        stream.valid && stream.last |-> bin_idx == '1);

    assert property (@(posedge clk) disable iff (!res)
        stream.valid && bin_idx != '0 |-> stream.pixel == $past(stream.pixel));

endmodule

// File: verilog/sifh_consts.svh
`ifndef SIFH_CONSTS_SVH
`define SIFH_CONSTS_SVH

// bin address width, 16 bins per pixel.
`define NB 4

// bin count width, counts saturate at 7.
`define PEAK_MAX 3

`define DATA_NUM 4   // photons per pixel per acquisition.
`define PIXEL_NUM 4  // pixels per acquisition.
`define PIX_W 2      // pixel index width.
`define ACQ_NUM 2    // acquisitions per frame.

// one histogram of 16 bins per pixel.
`define RAM_SIZE (`PIXEL_NUM * 16)

`endif

// File: verilog/sifh_pkg.sv
`include "sifh_consts.svh"

package sifh_pkg;

    typedef logic [`NB-1:0] bin_addr_t;
    typedef logic [`PEAK_MAX-1:0] bin_count_t;
    typedef logic [`PIX_W-1:0] pixel_idx_t;

    // pixel index on top, bin address below.
    typedef logic [`PIX_W+`NB-1:0] ram_addr_t;

    typedef enum logic [2:0] {
        CLEAR,
        INPUT,
        DRAIN,
        READOUT,
        FINISH
    } hist_state_t;

endpackage

// File: verilog/sifh_top.sv
`timescale 1ns/100ps

module sifh_top import sifh_pkg::*; (
    input  logic       clk,
    input  logic       res,
    input  logic       wr_en,
    input  bin_addr_t  addr,
    output logic       accepting,
    output logic       bin_valid,
    output bin_count_t bin_counts,
    output pixel_idx_t his_num,
    output logic       peak_valid,
    output bin_addr_t  peak_bin,
    output bin_count_t peak_count,
    output logic       data_finish
);

    hist_bus_if   hbus ();
    bin_stream_if bstream ();

    his_builder_fsm i_fsm (
        .clk         (clk),
        .res         (res),
        .wr_en       (wr_en),
        .addr        (addr),
        .accepting   (accepting),
        .his_num     (his_num),
        .data_finish (data_finish),
        .bus         (hbus.builder),
        .stream      (bstream.source)
    );

    hist_bram i_bram (
        .clk (clk),
        .res (res),
        .bus (hbus.ram)
    );

    peak_finder i_peak (
        .clk        (clk),
        .res        (res),
        .stream     (bstream.sink),
        .peak_valid (peak_valid),
        .peak_bin   (peak_bin),
        .peak_count (peak_count)
    );

    assign bin_valid  = bstream.valid;
    assign bin_counts = bstream.count;

endmodule
